// File: Bender.yml
package:
  name: knight_cmd

sources:
  - knight_pkg.sv
  - heading_err.sv
  - square_counter.sv
  - cmd_proc.sv
  - knight_cmd_top.sv
  - target: test
    files:
      - knight_cmd_checker.sv
      - tb_knight_cmd.sv

// File: build.f
knight_pkg.sv
heading_err.sv
square_counter.sv
cmd_proc.sv
knight_cmd_top.sv
knight_cmd_checker.sv
tb_knight_cmd.sv

// File: cmd_proc.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_proc #(
  parameter bit FAST_SIM = 1'b1  // Picks the large speed steps
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  knight_pkg::knight_cmd_t          cmd,          // Command word from link
  input  logic                             cmd_rdy,      // Command waiting
  input  logic                             cal_done,     // Gyro calibration done
  input  logic                             heading_rdy,  // New gyro reading
  input  knight_pkg::head_stat_t           stat,         // From heading path
  input  logic                             move_done,    // From line counter
  output logic                             load_cmd,     // Latch move fields
  output logic                             clr_cmd_rdy,  // Command consumed
  output logic                             strt_cal,     // Kick gyro calibration
  output logic                             send_resp,    // Command finished
  output logic                             tour_go,      // Kick tour engine
  output logic                             fanfare_go,   // Kick piezo fanfare
  output logic                             moving,       // Robot under way
  output logic [knight_pkg::FRWRD_W-1:0]   frwrd         // Forward speed
);

  import knight_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    CALIBRATE,
    ALIGN,
    RAMP_UP,
    RAMP_DOWN
  } state_e;

  state_e               state;       // Current state
  state_e               nxt_state;   // Next state
  opcode_e              op_q;        // Opcode of the running move
  logic [FRWRD_W-1:0]   inc_step;    // Ramp up step
  logic [FRWRD_W-1:0]   dec_step;    // Ramp down step
  logic                 frwrd_zero;  // Speed fully down
  logic                 frwrd_max;   // Speed saturated
  logic                 clr_frwrd;   // Restart speed at zero
  logic                 inc_frwrd;   // Ramp up enabled
  logic                 dec_frwrd;   // Ramp down enabled

  ////////////////////////////////////////////////////////////
  // Forward speed register
  ////////////////////////////////////////////////////////////

  assign inc_step = FAST_SIM ? INC_FAST : INC_SLOW;
  assign dec_step = FAST_SIM ? DEC_FAST : DEC_SLOW;

  assign frwrd_zero = (frwrd == '0);
  assign frwrd_max  = &frwrd[FRWRD_W-1 -: 2];  // Top two bits set

  // Steps land once per gyro sample so speed tracks the PID rate
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (clr_frwrd)
      frwrd <= '0;
    else if (heading_rdy && inc_frwrd && !frwrd_max)
      frwrd <= frwrd + inc_step;
    else if (heading_rdy && dec_frwrd) begin
      if (frwrd > dec_step)
        frwrd <= frwrd - dec_step;
      else
        frwrd <= '0;                     // Clamp, never wrap
    end
  end

  // Opcode kept so a new cmd on the link cannot change the fanfare choice
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      op_q <= MOVE;
    else if (load_cmd)
      op_q <= cmd.opcode;
  end

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state   = state;
    load_cmd    = 1'b0;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;

    case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;                 // Every opcode is consumed
          case (cmd.opcode)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOVE, FANFARE: begin
              load_cmd  = 1'b1;               // Side blocks latch fields
              nxt_state = ALIGN;
            end
            TOUR: tour_go = 1'b1;             // Tour engine takes over
            default: nxt_state = IDLE;        // Illegal opcode dropped
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end
      end

      // Hold still until the PID has turned us onto the heading
      ALIGN: begin
        if (stat.in_band) begin
          clr_frwrd = 1'b1;
          nxt_state = RAMP_UP;
        end
      end

      RAMP_UP: begin
        if (move_done) begin
          fanfare_go = (op_q == FANFARE);     // Charge on arrival
          nxt_state  = RAMP_DOWN;
        end else begin
          moving    = 1'b1;
          inc_frwrd = 1'b1;
        end
      end

      RAMP_DOWN: begin
        if (frwrd_zero) begin
          send_resp = 1'b1;                   // Stopped, report done
          nxt_state = IDLE;
        end else begin
          moving    = 1'b1;
          dec_frwrd = 1'b1;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: heading_err.sv
`timescale 1ns/1ps
`default_nettype none

module heading_err #(
  parameter bit FAST_SIM = 1'b1  // Picks the larger nudge
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  knight_pkg::ir_t                     ir,            // Raw async IR levels
  input  logic signed [knight_pkg::HEAD_W-1:0] heading,      // Gyro heading
  input  logic                                load_cmd,      // Latch new heading
  input  logic [7:0]                          heading_code,  // Command heading byte
  output knight_pkg::head_stat_t              stat
);

  import knight_pkg::*;

  logic [1:0]               lft_sync;         // [1] is the safe copy
  logic [1:0]               rght_sync;        // [1] is the safe copy
  logic signed [HEAD_W-1:0] nudge_mag;        // Nudge size for this build
  logic signed [HEAD_W-1:0] nudge;            // Signed nudge term
  logic signed [HEAD_W-1:0] desired_heading;  // Latched target heading
  logic signed [HEAD_W-1:0] err;              // Raw error
  logic                     in_band;          // Alignment reached

  ////////////////////////////////////////////////////////////
  // Side IR synchronizers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lft_sync  <= 2'b00;
      rght_sync <= 2'b00;
    end else begin
      lft_sync  <= {lft_sync[0], ir.lft};    // Shift in left sensor
      rght_sync <= {rght_sync[0], ir.rght};  // Shift in right sensor
    end
  end

  ////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////

  // Code 0 means due north, otherwise pad the low nibble with ones
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired_heading <= '0;
    else if (load_cmd) begin
      if (heading_code == 8'h00)
        desired_heading <= '0;
      else
        desired_heading <= {heading_code, 4'hF};
    end
  end

  ////////////////////////////////////////////////////////////
  // Error and band
  ////////////////////////////////////////////////////////////

  assign nudge_mag = FAST_SIM ? NUDGE_FAST : NUDGE_SLOW;

  // Left wins when both sensors see the edge
  assign nudge = lft_sync[1]  ? nudge_mag  :
                 rght_sync[1] ? -nudge_mag :
                 '0;

  assign err = heading - desired_heading + nudge;  // Wraps like the gyro

  assign in_band = (err > -ERR_BAND) && (err < ERR_BAND);  // Open interval

  assign stat = '{err: err, in_band: in_band};

endmodule

`default_nettype wire

// File: knight_cmd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module knight_cmd_checker (
  input logic                           clk,
  input logic                           rst_n,
  input logic [2:0]                     state,        // FSM state with IDLE encoded as 0
  input logic                           clr_cmd_rdy,
  input logic                           strt_cal,
  input logic                           send_resp,
  input logic                           tour_go,
  input logic                           fanfare_go,
  input logic                           moving,
  input logic [knight_pkg::FRWRD_W-1:0] frwrd
);

  import knight_pkg::*;

  // A strobe must drop in the cycle after it fires
  property single_cycle(p);
    @(posedge clk) disable iff (!rst_n) p |=> !p;
  endproperty

  a_clr_pulse: assert property (single_cycle(clr_cmd_rdy))
    else $error("clr_cmd_rdy held longer than one cycle");
  a_cal_pulse: assert property (single_cycle(strt_cal))
    else $error("strt_cal held longer than one cycle");
  a_resp_pulse: assert property (single_cycle(send_resp))
    else $error("send_resp held longer than one cycle");
  a_tour_pulse: assert property (single_cycle(tour_go))
    else $error("tour_go held longer than one cycle");
  a_fan_pulse: assert property (single_cycle(fanfare_go))
    else $error("fanfare_go held longer than one cycle");

  // Ramp stops once the top two bits are set
  a_frwrd_sat: assert property (@(posedge clk) disable iff (!rst_n)
    frwrd <= {2'b11, {(FRWRD_W-2){1'b0}}})
    else $error("frwrd above saturation");

  // Every move ends fully stopped before the FSM is back in IDLE
  a_idle_still: assert property (@(posedge clk) disable iff (!rst_n)
    (state == 3'd0) |-> (frwrd == '0 && !moving))
    else $error("speed left over or moving high while idle");

endmodule

bind cmd_proc knight_cmd_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .state       (state),
  .clr_cmd_rdy (clr_cmd_rdy),
  .strt_cal    (strt_cal),
  .send_resp   (send_resp),
  .tour_go     (tour_go),
  .fanfare_go  (fanfare_go),
  .moving      (moving),
  .frwrd       (frwrd)
);

`default_nettype wire

// File: knight_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module knight_cmd_top #(
  parameter bit FAST_SIM = 1'b1  // Short ramps and big nudges in simulation
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  knight_pkg::knight_cmd_t              cmd,          // Command word
  input  logic                                 cmd_rdy,      // Command waiting
  input  logic                                 cal_done,     // Gyro calibrated
  input  logic signed [knight_pkg::HEAD_W-1:0] heading,      // Gyro heading
  input  logic                                 heading_rdy,  // Gyro sample strobe
  input  knight_pkg::ir_t                      ir,           // Raw IR levels
  output logic                                 clr_cmd_rdy,
  output logic                                 strt_cal,
  output logic                                 send_resp,
  output logic                                 tour_go,
  output logic                                 fanfare_go,
  output logic                                 moving,
  output logic signed [knight_pkg::HEAD_W-1:0] error,        // To PID
  output logic [knight_pkg::FRWRD_W-1:0]       frwrd         // To PID
);

  import knight_pkg::*;

  logic       load_cmd;   // Move accepted
  head_stat_t stat;       // Heading path result
  logic       move_done;  // Line path result

  heading_err #(.FAST_SIM(FAST_SIM)) u_heading_err (
    .clk          (clk),
    .rst_n        (rst_n),
    .ir           (ir),
    .heading      (heading),
    .load_cmd     (load_cmd),
    .heading_code (cmd.heading_code),
    .stat         (stat)
  );

  square_counter u_square_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cntr_ir   (ir.cntr),
    .load_cmd  (load_cmd),
    .squares   (cmd.squares),
    .move_done (move_done)
  );

  cmd_proc #(.FAST_SIM(FAST_SIM)) u_cmd_proc (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .heading_rdy (heading_rdy),
    .stat        (stat),
    .move_done   (move_done),
    .load_cmd    (load_cmd),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .frwrd       (frwrd)
  );

  assign error = stat.err;  // PID sees the raw error

endmodule

`default_nettype wire

// File: knight_pkg.sv
`default_nettype none

package knight_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////

  localparam int HEAD_W  = 12;  // Gyro heading and PID error width
  localparam int FRWRD_W = 10;  // Forward speed register width

  // Error must sit strictly inside +/- this to start a move
  localparam logic signed [HEAD_W-1:0] ERR_BAND = 12'sh02C;

  // Forward speed steps, one per heading_rdy
  localparam logic [FRWRD_W-1:0] INC_FAST = 10'h020;  // Ramp up, short sims
  localparam logic [FRWRD_W-1:0] DEC_FAST = 10'h040;  // Ramp down, short sims
  localparam logic [FRWRD_W-1:0] INC_SLOW = 10'h003;  // Ramp up, real robot
  localparam logic [FRWRD_W-1:0] DEC_SLOW = 10'h006;  // Ramp down, real robot

  // Side IR nudge, left adds it and right subtracts it
  localparam logic signed [HEAD_W-1:0] NUDGE_FAST = 12'sh1FF;
  localparam logic signed [HEAD_W-1:0] NUDGE_SLOW = 12'sh05F;

  ////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    CAL     = 4'b0010,  // Start gyro calibration
    MOVE    = 4'b0100,  // Plain move
    FANFARE = 4'b0101,  // Move, then charge fanfare
    TOUR    = 4'b0110   // Hand off to tour engine
  } opcode_e;

  typedef struct packed {
    opcode_e    opcode;        // cmd[15:12]
    logic [7:0] heading_code;  // cmd[11:4], upper byte of heading
    logic [3:0] squares;       // cmd[3:0], squares to cover
  } knight_cmd_t;

  ////////////////////////////////////////////////////////////
  // Sensor and status bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic lft;   // Left IR, robot drifting right
    logic cntr;  // Centre IR, high over a board line
    logic rght;  // Right IR, robot drifting left
  } ir_t;

  typedef struct packed {
    logic signed [HEAD_W-1:0] err;      // Heading error to PID
    logic                     in_band;  // |err| below ERR_BAND
  } head_stat_t;

endpackage

`default_nettype wire

// File: knight_testdata.txt
# name  cmd  heading  side_ir(lft,rght)  exp_error  pulses(clr,strt,resp,tour,fan)  exp_peak_frwrd
# cmd, heading, exp_error and exp_peak_frwrd in hex; side_ir and pulses in binary
cal_first      2000 000 00 000 11100 000
move_left      43F2 500 10 300 10100 300
fanfare_right  5803 000 01 5F2 10101 300
tour_handoff   6000 000 00 000 10010 000
move_both_ir   4002 F00 11 0FF 10100 300
illegal_op     F123 000 00 000 10000 000
move_zero      4120 000 00 ED1 10100 000
fanfare_far    5C42 7FF 00 BB0 10101 300
cal_second     2000 000 00 000 11100 000

// File: square_counter.sv
`timescale 1ns/1ps
`default_nettype none

module square_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cntr_ir,    // Raw async centre IR
  input  logic       load_cmd,   // New move, latch squares
  input  logic [3:0] squares,    // Squares from the command
  output logic       move_done   // Enough lines crossed
);

  logic [2:0] cntr_sync;  // [1:0] synchronizer, [2] history
  logic       line_rise;  // Clean rising edge
  logic [3:0] squares_q;  // Latched square count
  logic [4:0] line_cnt;   // Lines seen this move

  ////////////////////////////////////////////////////////////
  // Centre IR synchronizer and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cntr_sync <= 3'b000;
    else
      cntr_sync <= {cntr_sync[1:0], cntr_ir};  // Shift in centre sensor
  end

  assign line_rise = cntr_sync[1] & ~cntr_sync[2];  // Low to high on safe copy

  ////////////////////////////////////////////////////////////
  // Square target and line count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      squares_q <= 4'h0;
    else if (load_cmd)
      squares_q <= squares;  // Hold for the whole move
  end

  // Saturate so a stray edge storm cannot wrap back to the target
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      line_cnt <= 5'h00;
    else if (load_cmd)
      line_cnt <= 5'h00;                 // Fresh count per move
    else if (line_rise && (line_cnt != 5'h1F))
      line_cnt <= line_cnt + 5'h01;
  end

  // Each square is bounded by two lines
  assign move_done = (line_cnt == {squares_q, 1'b0});

endmodule

`default_nettype wire

// File: tb_knight_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_knight_cmd;

  import knight_pkg::*;

  logic              clk = 1'b0;
  logic              rst_n;
  knight_cmd_t       cmd;
  logic              cmd_rdy;
  logic              cal_done;
  logic [HEAD_W-1:0] heading;            // Gyro model output
  logic              heading_rdy;        // Gyro model strobe
  ir_t               ir;
  logic              clr_cmd_rdy;
  logic              strt_cal;
  logic              send_resp;
  logic              tour_go;
  logic              fanfare_go;
  logic              moving;
  logic [HEAD_W-1:0] error;              // Compared as raw bits
  logic [FRWRD_W-1:0] frwrd;

  string             rec_name [0:31];    // Scenario table from the data file
  logic [15:0]       rec_cmd [0:31];
  logic [HEAD_W-1:0] rec_head [0:31];
  logic [1:0]        rec_side [0:31];    // {lft, rght}
  logic [HEAD_W-1:0] rec_err [0:31];
  logic [4:0]        rec_pulse [0:31];   // {clr, strt, resp, tour, fan}
  logic [FRWRD_W-1:0] rec_peak [0:31];
  int                n_recs;
  int                cyc_bound = 100;    // Grows with every record read
  bit                load_done;
  integer            fd;
  integer            seed;
  string             line;
  string             cur_name;
  logic [3:0]        op;
  int                n_errors;
  int                n_checks;

  logic [HEAD_W-1:0] gyro_target;        // Heading the gyro reports next
  logic [1:0]        side_ir;            // {lft, rght}
  logic              cntr_line;
  logic [1:0]        hr_phase = 2'd0;
  int                n_clr;
  int                n_strt;
  int                n_resp;
  int                n_tour;
  int                n_fan;
  int                n_moving;
  logic [FRWRD_W-1:0] prev_frwrd;
  logic              prev_hr;
  logic [FRWRD_W-1:0] frwrd_peak;

  assign ir = '{lft: side_ir[1], cntr: cntr_line, rght: side_ir[0]};

  knight_cmd_top #(.FAST_SIM(1'b1)) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .ir          (ir),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .error       (error),
    .frwrd       (frwrd)
  );

  ////////////////////////////////////////////////////////////
  // Clock, gyro model and output monitors
  ////////////////////////////////////////////////////////////

  initial begin
    forever #50 clk = ~clk;  // 100 ns period
  end

  // New gyro reading every fourth cycle
  always @(negedge clk) begin
    hr_phase    = hr_phase + 2'd1;
    heading_rdy = (hr_phase == 2'd0);
    if (heading_rdy)
      heading = gyro_target;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      n_clr    = n_clr + clr_cmd_rdy;
      n_strt   = n_strt + strt_cal;
      n_resp   = n_resp + send_resp;
      n_tour   = n_tour + tour_go;
      n_fan    = n_fan + fanfare_go;
      n_moving = n_moving + moving;
      if (frwrd != prev_frwrd) begin
        check("ramp_strobe", 1, prev_hr);                // Speed moves only on a gyro sample
        if (frwrd > prev_frwrd) begin
          check("ramp_sat", 0, &prev_frwrd[FRWRD_W-1 -: 2]);
          check("ramp_up", prev_frwrd + INC_FAST, frwrd);
        end else
          check("ramp_down", (prev_frwrd > DEC_FAST) ? prev_frwrd - DEC_FAST : 0, frwrd);
      end
      if (frwrd > frwrd_peak)
        frwrd_peak = frwrd;
    end
    prev_frwrd = frwrd;
    prev_hr    = heading_rdy;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("mismatch %0s %0s: expected %0h actual %0h", cur_name, label, exp, act);
    end
  endtask

  // Code 0 is north, otherwise the code sits above four ones
  function automatic logic [HEAD_W-1:0] desired_of(input logic [7:0] code);
    return (code == 8'h00) ? '0 : {code, 4'hF};
  endfunction

  task automatic clear_counts;
    n_clr      = 0;
    n_strt     = 0;
    n_resp     = 0;
    n_tour     = 0;
    n_fan      = 0;
    n_moving   = 0;
    frwrd_peak = '0;
  endtask

  task automatic issue_cmd(input logic [15:0] word);
    @(negedge clk);
    cmd     = word;
    cmd_rdy = 1'b1;
    do @(posedge clk); while (clr_cmd_rdy !== 1'b1);  // Consumed in IDLE only
    @(negedge clk);
    cmd_rdy = 1'b0;
  endtask

  task automatic await_resp;
    do @(posedge clk); while (send_resp !== 1'b1);
  endtask

  // Board lines pass under the centre sensor at random gaps
  task automatic centre_edges(input int n_edges);
    int k;
    if (n_edges > 0) begin
      while (moving !== 1'b1)
        @(negedge clk);
      for (k = 0; k < n_edges; k++) begin
        repeat (30 + ($random(seed) & 31)) @(negedge clk);
        cntr_line = 1'b1;
        repeat (10) @(negedge clk);
        cntr_line = 1'b0;
      end
    end
  endtask

  task automatic calibration(input int i);
    issue_cmd(rec_cmd[i]);
    repeat (10) @(negedge clk);
    check("early_resp", 0, n_resp);  // Gyro still busy
    cal_done = 1'b1;
    await_resp();
    @(negedge clk);
    cal_done = 1'b0;
  endtask

  task automatic drive_move(input int i);
    knight_cmd_t c;
    c           = rec_cmd[i];
    gyro_target = rec_head[i];
    side_ir     = rec_side[i];
    repeat (8) @(negedge clk);                 // Gyro sample and IR sync settle
    issue_cmd(rec_cmd[i]);
    repeat (4) @(negedge clk);
    check("error", rec_err[i], error);
    repeat (20) begin                          // Still off heading
      @(negedge clk);
      check("gate_moving", 0, moving);
      check("gate_frwrd", 0, frwrd);
    end
    gyro_target = desired_of(c.heading_code);  // PID has turned the robot
    side_ir     = 2'b00;
    fork
      centre_edges(2 * c.squares);
      await_resp();
    join
    check("moving_rise", c.squares != 4'h0, n_moving != 0);
  endtask

  task automatic quick_command(input int i);
    issue_cmd(rec_cmd[i]);
    repeat (10) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    cmd = '0;
    cmd_rdy = 1'b0;
    cal_done = 1'b0;
    heading = '0;
    heading_rdy = 1'b0;
    gyro_target = '0;
    side_ir = 2'b00;
    cntr_line = 1'b0;
    prev_frwrd = '0;
    prev_hr = 1'b0;
    seed = 56;
    clear_counts();
    fd = $fopen("knight_testdata.txt", "r");
    if (fd == 0)
      $display("could not open knight_testdata.txt");
    else begin
      while (!$feof(fd) && n_recs < 32) begin
        if ($fgets(line, fd) != 0)
          if ($sscanf(line, "%s %h %h %b %h %b %h", rec_name[n_recs], rec_cmd[n_recs],
                      rec_head[n_recs], rec_side[n_recs], rec_err[n_recs],
                      rec_pulse[n_recs], rec_peak[n_recs]) == 7) begin
            cyc_bound = cyc_bound + 300 + 160 * rec_cmd[n_recs][3:0];  // Lines dominate
            n_recs++;
          end
      end
      $fclose(fd);
    end
    load_done = 1'b1;
    if (n_recs == 0) begin
      $display("no test records were read from the data file");
      n_errors++;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_recs; i++) begin
      cur_name = rec_name[i];
      clear_counts();
      op = rec_cmd[i][15:12];
      if (op == CAL)
        calibration(i);
      else if (op == MOVE || op == FANFARE)
        drive_move(i);
      else
        quick_command(i);                      // Tour and illegal opcodes
      repeat (4) @(negedge clk);
      check("clr_cmd_rdy", rec_pulse[i][4], n_clr);
      check("strt_cal", rec_pulse[i][3], n_strt);
      check("send_resp", rec_pulse[i][2], n_resp);
      check("tour_go", rec_pulse[i][1], n_tour);
      check("fanfare_go", rec_pulse[i][0], n_fan);
      check("frwrd_end", 0, frwrd);
      check("frwrd_peak", rec_peak[i], frwrd_peak);
    end
    $display("records: %0d checks: %0d errors: %0d", n_recs, n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    wait (load_done);
    #(cyc_bound * 100);
    $display("watchdog expired after %0d cycles before the scenarios finished", cyc_bound);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
